//--- Makefile
# Verilator build and run for the hazard unit testbench

VERILATOR ?= verilator
TOP       ?= hazard_unit_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard rtl/*.sv tests/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
rtl/hazard_pkg.sv
rtl/stage_reg.sv
rtl/hazard_detect.sv
rtl/trap_track.sv
rtl/hazard_unit.sv
tests/tb_clock.sv
tests/hazard_unit_assertions.sv
tests/hazard_unit_tb.sv

//--- rtl/hazard_detect.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_detect (
    input  hazard_pkg::reg_idx_t     id_rs1,
    input  hazard_pkg::reg_idx_t     id_rs2,
    input  hazard_pkg::reg_idx_t     ex_rd,
    input  logic                     ex_mem_read,
    input  logic                     pc_sel,
    input  logic                     csr_branch,
    input  logic                     jump_taken,
    input  logic                     stall_imem,
    input  logic                     stall_dmem,
    input  logic                     trap_pending,
    output hazard_pkg::hazard_code_t hazard
);
    import hazard_pkg::*;

    logic redirect;
    logic mem_stall;
    logic load_use;

    ////////////////////
    // Conditions
    ////////////////////

    // Any redirect of the PC flushes the whole pipe
    assign redirect  = pc_sel | csr_branch | trap_pending;
    assign mem_stall = stall_imem | stall_dmem;

    // x0 never carries a dependency
    assign load_use = ex_mem_read
                    && (ex_rd != '0)
                    && ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    ////////////////////
    // Priority
    ////////////////////

    always_comb begin
        if (redirect) begin
            hazard = HC_FLUSH_ALL;
        end else if (mem_stall) begin
            hazard = HC_STALL_MMU;
        end else if (jump_taken) begin
            hazard = HC_FLUSH_EARLY;
        end else if (load_use) begin
            hazard = HC_STALL_EARLY;
        end else begin
            hazard = HC_NONE;
        end
    end

endmodule

`default_nettype wire

//--- rtl/hazard_pkg.sv
`default_nettype none

package hazard_pkg;

    ////////////////////
    // Basic vectors
    ////////////////////

    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  trap_id_t;

    ////////////////////
    // Pipeline control
    ////////////////////

    // Ordered by priority, so a larger code always wins
    typedef enum logic [2:0] {
        HC_NONE        = 3'd0,
        HC_STALL_EARLY = 3'd1,
        HC_FLUSH_EARLY = 3'd2,
        HC_STALL_MMU   = 3'd3,
        HC_FLUSH_ALL   = 3'd4
    } hazard_code_t;

    // Register boundaries, named after the stage they feed
    typedef enum logic [1:0] {
        STAGE_ID  = 2'd0,
        STAGE_EX  = 2'd1,
        STAGE_MEM = 2'd2
    } stage_t;

    ////////////////////
    // Trap causes
    ////////////////////

    // RISC-V mcause exception codes
    localparam trap_id_t TRAP_MISALIGNED_PC    = 5'd0;
    localparam trap_id_t TRAP_ILLEGAL_INST     = 5'd2;
    localparam trap_id_t TRAP_INST_PAGE_FAULT  = 5'd12;
    localparam trap_id_t TRAP_LOAD_PAGE_FAULT  = 5'd13;
    localparam trap_id_t TRAP_STORE_PAGE_FAULT = 5'd15;
    // Not a real cause, marks an idle cycle
    localparam trap_id_t TRAP_NONE             = 5'd31;

    ////////////////////
    // Fault bundles
    ////////////////////

    // Faults raised by fetch, travels from IF/ID onwards
    typedef struct packed {
        logic  pc_misaligned;
        logic  inst_fault;
        logic  load_fault;
        logic  store_fault;
        word_t va;
    } fetch_fault_t;

    // Faults raised by the data side in MEM
    typedef struct packed {
        logic inst_fault;
        logic load_fault;
        logic store_fault;
    } mem_fault_t;

    // Fetch faults plus the decoded word, from ID/EX onwards
    typedef struct packed {
        fetch_fault_t fetch;
        logic         invalid_inst;
        word_t        inst;
    } ex_bundle_t;

    localparam int ID_BUNDLE_W = $bits(fetch_fault_t);
    localparam int EX_BUNDLE_W = $bits(ex_bundle_t);

endpackage

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    input  logic                     clk,
    input  logic                     rst_n,

    // Operands
    input  hazard_pkg::reg_idx_t     id_rs1,
    input  hazard_pkg::reg_idx_t     id_rs2,
    input  hazard_pkg::reg_idx_t     ex_rd,
    input  logic                     ex_mem_read,

    // Redirects
    input  logic                     pc_sel,
    input  logic                     csr_branch,
    input  logic                     jump_taken,

    // Memory stalls
    input  logic                     stall_imem,
    input  logic                     stall_dmem,

    // Faults
    input  hazard_pkg::fetch_fault_t fetch_fault,
    input  logic                     invalid_inst,
    input  hazard_pkg::word_t        decode_inst,
    input  hazard_pkg::mem_fault_t   dmem_fault,

    output hazard_pkg::hazard_code_t hazard,
    output hazard_pkg::trap_id_t     trap_id,
    output hazard_pkg::word_t        fault_inst,
    output hazard_pkg::word_t        fault_va
);
    import hazard_pkg::*;

    logic trap_pending;

    // A taken trap flushes everything behind it
    assign trap_pending = (trap_id != TRAP_NONE);

    hazard_detect detect_i (
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .ex_rd       (ex_rd),
        .ex_mem_read (ex_mem_read),
        .pc_sel      (pc_sel),
        .csr_branch  (csr_branch),
        .jump_taken  (jump_taken),
        .stall_imem  (stall_imem),
        .stall_dmem  (stall_dmem),
        .trap_pending(trap_pending),
        .hazard      (hazard)
    );

    // Same control code as the datapath registers
    trap_track track_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .hazard      (hazard),
        .fetch_fault (fetch_fault),
        .invalid_inst(invalid_inst),
        .decode_inst (decode_inst),
        .dmem_fault  (dmem_fault),
        .trap_id     (trap_id),
        .fault_inst  (fault_inst),
        .fault_va    (fault_va)
    );

endmodule

`default_nettype wire

//--- rtl/stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
    parameter hazard_pkg::stage_t STAGE = hazard_pkg::STAGE_ID,
    parameter int                 WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  hazard_pkg::hazard_code_t hazard,
    input  logic [WIDTH-1:0]         d,
    output logic [WIDTH-1:0]         q
);
    import hazard_pkg::*;

    logic load;
    logic clear;

    // Boundary action for this stage
    always_comb begin
        case (hazard)
            HC_FLUSH_ALL: begin
                load  = 1'b0;
                clear = 1'b1;
            end
            HC_STALL_MMU: begin
                load  = 1'b0;
                clear = 1'b0;
            end
            HC_FLUSH_EARLY: begin
                // Jump kills the instruction in ID only
                load  = (STAGE != STAGE_ID);
                clear = (STAGE == STAGE_ID);
            end
            HC_STALL_EARLY: begin
                // ID holds, bubble into EX, MEM drains
                load  = (STAGE == STAGE_MEM);
                clear = (STAGE == STAGE_EX);
            end
            HC_NONE: begin
                load  = 1'b1;
                clear = 1'b0;
            end
            default: begin
                load  = 1'b0;
                clear = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- rtl/trap_track.sv
`timescale 1ns/10ps
`default_nettype none

module trap_track (
    input  logic                     clk,
    input  logic                     rst_n,
    input  hazard_pkg::hazard_code_t hazard,
    input  hazard_pkg::fetch_fault_t fetch_fault,
    input  logic                     invalid_inst,
    input  hazard_pkg::word_t        decode_inst,
    input  hazard_pkg::mem_fault_t   dmem_fault,
    output hazard_pkg::trap_id_t     trap_id,
    output hazard_pkg::word_t        fault_inst,
    output hazard_pkg::word_t        fault_va
);
    import hazard_pkg::*;

    fetch_fault_t id_q;
    ex_bundle_t   ex_d;
    ex_bundle_t   ex_q;
    ex_bundle_t   mem_q;

    logic any_inst_fault;
    logic any_load_fault;
    logic any_store_fault;

    ////////////////////
    // Shadow pipeline
    ////////////////////

    // IF/ID boundary, fetch faults only
    stage_reg #(
        .STAGE(STAGE_ID),
        .WIDTH(ID_BUNDLE_W)
    ) id_reg_i (
        .clk   (clk),
        .rst_n (rst_n),
        .hazard(hazard),
        .d     (fetch_fault),
        .q     (id_q)
    );

    // Decode adds its own fault and the instruction word
    assign ex_d = '{
        fetch:        id_q,
        invalid_inst: invalid_inst,
        inst:         decode_inst
    };

    // ID/EX boundary
    stage_reg #(
        .STAGE(STAGE_EX),
        .WIDTH(EX_BUNDLE_W)
    ) ex_reg_i (
        .clk   (clk),
        .rst_n (rst_n),
        .hazard(hazard),
        .d     (ex_d),
        .q     (ex_q)
    );

    // EX/MEM boundary, nothing new joins in EX
    stage_reg #(
        .STAGE(STAGE_MEM),
        .WIDTH(EX_BUNDLE_W)
    ) mem_reg_i (
        .clk   (clk),
        .rst_n (rst_n),
        .hazard(hazard),
        .d     (ex_q),
        .q     (mem_q)
    );

    ////////////////////
    // Trap cause
    ////////////////////

    // Data side faults join those carried down from fetch
    assign any_inst_fault  = mem_q.fetch.inst_fault  | dmem_fault.inst_fault;
    assign any_load_fault  = mem_q.fetch.load_fault  | dmem_fault.load_fault;
    assign any_store_fault = mem_q.fetch.store_fault | dmem_fault.store_fault;

    always_comb begin
        if (mem_q.fetch.pc_misaligned) begin
            trap_id = TRAP_MISALIGNED_PC;
        end else if (mem_q.fetch.inst_fault) begin
            // Older than anything decode could report
            trap_id = TRAP_INST_PAGE_FAULT;
        end else if (mem_q.invalid_inst) begin
            trap_id = TRAP_ILLEGAL_INST;
        end else if (any_inst_fault) begin
            trap_id = TRAP_INST_PAGE_FAULT;
        end else if (any_load_fault) begin
            trap_id = TRAP_LOAD_PAGE_FAULT;
        end else if (any_store_fault) begin
            trap_id = TRAP_STORE_PAGE_FAULT;
        end else begin
            trap_id = TRAP_NONE;
        end
    end

    // Reported for the trap handler, valid whenever trap_id is
    assign fault_inst = mem_q.inst;
    assign fault_va   = mem_q.fetch.va;

endmodule

`default_nettype wire

//--- tests/hazard_unit_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     stall_imem,
    input logic                     stall_dmem,
    input hazard_pkg::hazard_code_t hazard,
    input hazard_pkg::trap_id_t     trap_id,
    input hazard_pkg::word_t        fault_inst,
    input hazard_pkg::word_t        fault_va
);
    import hazard_pkg::*;

    // A reported trap always flushes the pipe
    trap_forces_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        (trap_id != TRAP_NONE) |-> (hazard == HC_FLUSH_ALL)
    ) else $error("trap reported without a full flush");

    // Memory stalls beat jumps and load-use
    stall_wins: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall_imem || stall_dmem) |-> (hazard >= HC_STALL_MMU)
    ) else $error("memory stall lost to a lower priority code");

    outputs_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown({hazard, trap_id, fault_inst, fault_va})
    ) else $error("unknown value on a hazard unit output");

endmodule

`default_nettype wire

//--- tests/hazard_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit_tb;
    import hazard_pkg::*;

    // ctl is {pc_sel, csr_branch, jump_taken, stall_imem, stall_dmem}
    // ops is {ex_mem_read, ex_rd, id_rs1, id_rs2}
    typedef struct packed {
        logic [4:0]   ctl;
        logic [15:0]  ops;
        fetch_fault_t fetch;
        logic         invalid;
        word_t        inst;
        mem_fault_t   dmem;
        hazard_code_t exp_hazard;
        trap_id_t     exp_trap;
        word_t        exp_inst;
        word_t        exp_va;
    } row_t;

    logic         clk;
    logic         rst_n;
    reg_idx_t     id_rs1;
    reg_idx_t     id_rs2;
    reg_idx_t     ex_rd;
    logic         ex_mem_read;
    logic         pc_sel;
    logic         csr_branch;
    logic         jump_taken;
    logic         stall_imem;
    logic         stall_dmem;
    fetch_fault_t fetch_fault;
    logic         invalid_inst;
    word_t        decode_inst;
    mem_fault_t   dmem_fault;
    hazard_code_t hazard;
    trap_id_t     trap_id;
    word_t        fault_inst;
    word_t        fault_va;

    row_t rows[$];
    int   cycles = 0;
    int   limit  = 0;

    tb_clock clock_i (
        .clk  (clk),
        .rst_n(rst_n)
    );

    hazard_unit dut_i (.*);

    bind hazard_unit hazard_unit_assertions assertions_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall_imem(stall_imem),
        .stall_dmem(stall_dmem),
        .hazard    (hazard),
        .trap_id   (trap_id),
        .fault_inst(fault_inst),
        .fault_va  (fault_va)
    );

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic add_row(input logic [4:0] ctl, input logic [15:0] ops,
                           input fetch_fault_t fetch, input logic invalid, input word_t inst,
                           input mem_fault_t dmem, input hazard_code_t exp_hazard,
                           input trap_id_t exp_trap, input word_t exp_inst,
                           input word_t exp_va);
        row_t r;
        r.ctl        = ctl;
        r.ops        = ops;
        r.fetch      = fetch;
        r.invalid    = invalid;
        r.inst       = inst;
        r.dmem       = dmem;
        r.exp_hazard = exp_hazard;
        r.exp_trap   = exp_trap;
        r.exp_inst   = exp_inst;
        r.exp_va     = exp_va;
        rows.push_back(r);
    endtask

    // Quiet cycle with an empty MEM boundary
    task automatic add_idle();
        add_row(5'b00000, 16'h0000, '0, 1'b0, '0, '0, HC_NONE, TRAP_NONE, '0, '0);
    endtask

    task automatic drive_row(input row_t r);
        {pc_sel, csr_branch, jump_taken, stall_imem, stall_dmem} = r.ctl;
        {ex_mem_read, ex_rd, id_rs1, id_rs2} = r.ops;
        fetch_fault  = r.fetch;
        invalid_inst = r.invalid;
        decode_inst  = r.inst;
        dmem_fault   = r.dmem;
    endtask

    task automatic check_row(input int idx, input row_t r);
        check_value($sformatf("row %0d hazard", idx), 32'(hazard), 32'(r.exp_hazard));
        check_value($sformatf("row %0d trap_id", idx), 32'(trap_id), 32'(r.exp_trap));
        check_value($sformatf("row %0d fault_inst", idx), fault_inst, r.exp_inst);
        check_value($sformatf("row %0d fault_va", idx), fault_va, r.exp_va);
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic build_table();
        // Control code priority
        add_row(5'b10101, {1'b1, 5'd5, 5'd5, 5'd0}, '0, 1'b0, '0, '0,
                HC_FLUSH_ALL, TRAP_NONE, '0, '0);
        add_row(5'b00101, {1'b1, 5'd5, 5'd5, 5'd0}, '0, 1'b0, '0, '0,
                HC_STALL_MMU, TRAP_NONE, '0, '0);
        add_row(5'b00100, {1'b1, 5'd5, 5'd5, 5'd0}, '0, 1'b0, '0, '0,
                HC_FLUSH_EARLY, TRAP_NONE, '0, '0);
        add_row(5'b00000, {1'b1, 5'd7, 5'd3, 5'd7}, '0, 1'b0, '0, '0,
                HC_STALL_EARLY, TRAP_NONE, '0, '0);
        // Load-use on rs1 and no stall without a load
        add_row(5'b00000, {1'b1, 5'd9, 5'd9, 5'd4}, '0, 1'b0, '0, '0,
                HC_STALL_EARLY, TRAP_NONE, '0, '0);
        add_row(5'b00000, {1'b0, 5'd9, 5'd9, 5'd9}, '0, 1'b0, '0, '0,
                HC_NONE, TRAP_NONE, '0, '0);
        // x0 as destination never stalls
        add_row(5'b00000, {1'b1, 5'd0, 5'd0, 5'd0}, '0, 1'b0, '0, '0,
                HC_NONE, TRAP_NONE, '0, '0);
        add_row(5'b01010, 16'h0000, '0, 1'b0, '0, '0,
                HC_FLUSH_ALL, TRAP_NONE, '0, '0);

        // Misaligned PC takes three edges to MEM
        add_row(5'b00000, 16'h0000, {4'b1000, 32'h0000_1002}, 1'b0, '0, '0,
                HC_NONE, TRAP_NONE, '0, '0);
        add_idle();
        add_idle();
        add_row(5'b00000, 16'h0000, '0, 1'b0, '0, '0,
                HC_FLUSH_ALL, TRAP_MISALIGNED_PC, '0, 32'h0000_1002);
        add_idle();

        // Illegal instruction from decode takes two edges
        add_row(5'b00000, 16'h0000, '0, 1'b1, 32'hdead_beef, '0,
                HC_NONE, TRAP_NONE, '0, '0);
        add_idle();
        add_row(5'b00000, 16'h0000, '0, 1'b0, '0, '0,
                HC_FLUSH_ALL, TRAP_ILLEGAL_INST, 32'hdead_beef, '0);

        // MMU stall delays the fault by one cycle
        add_row(5'b00000, 16'h0000, {4'b0100, 32'h0000_2000}, 1'b0, '0, '0,
                HC_NONE, TRAP_NONE, '0, '0);
        add_row(5'b00010, 16'h0000, '0, 1'b0, '0, '0,
                HC_STALL_MMU, TRAP_NONE, '0, '0);
        add_idle();
        add_idle();
        add_row(5'b00000, 16'h0000, '0, 1'b0, '0, '0,
                HC_FLUSH_ALL, TRAP_INST_PAGE_FAULT, '0, 32'h0000_2000);

        // Fault fetched behind a jump dies at IF/ID
        add_row(5'b00100, 16'h0000, {4'b1000, 32'h0000_3000}, 1'b0, '0, '0,
                HC_FLUSH_EARLY, TRAP_NONE, '0, '0);
        add_idle();
        add_idle();
        add_idle();

        // Data side faults
        add_row(5'b00000, 16'h0000, '0, 1'b0, '0, 3'b001,
                HC_FLUSH_ALL, TRAP_STORE_PAGE_FAULT, '0, '0);
        add_row(5'b00000, 16'h0000, '0, 1'b0, '0, 3'b011,
                HC_FLUSH_ALL, TRAP_LOAD_PAGE_FAULT, '0, '0);
        add_row(5'b00000, 16'h0000, {4'b0100, 32'h0000_4000}, 1'b0, '0, '0,
                HC_NONE, TRAP_NONE, '0, '0);
        add_idle();
        add_idle();
        add_row(5'b00000, 16'h0000, '0, 1'b0, '0, 3'b010,
                HC_FLUSH_ALL, TRAP_INST_PAGE_FAULT, '0, 32'h0000_4000);
    endtask

    ////////////////////
    // Run
    ////////////////////

    initial begin
        row_t blank;
        blank = '0;
        drive_row(blank);
        build_table();
        limit = rows.size() + 20;
        wait (rst_n === 1'b1);
        foreach (rows[i]) begin
            @(negedge clk);
            drive_row(rows[i]);
            // Sample just ahead of the next rising edge
            #4;
            check_row(i, rows[i]);
        end
        $display("=== PASS ===");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: table did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release lands after the last reset edge has been seen
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
